// ==== stream_dram.f ====
hw/stream_dram_pkg.sv
hw/frame_writer.sv
hw/frame_queue.sv
hw/frame_reader.sv
hw/burst_arbiter.sv
hw/frame_store_ram.sv
hw/stream_dram_top.sv
verif/stream_dram_checker.sv
verif/stream_dram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module stream_dram_tb \
   -f stream_dram.f -o stream_dram_sim
./obj_dir/stream_dram_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: no errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== verif/stream_dram_tb.sv ====
//////////////////////////////////////////////////
// directed tests for the stream frame store
// expected data comes from a local model of the
// header length rule; stops at the first error
//////////////////////////////////////////////////
`timescale 1ns/1ps
module stream_dram_tb;

   typedef logic [15:0] half_q_t [$];

   localparam int HDR_HALVES  = 16;
   localparam int LEN_LO_IDX  = 2;
   localparam int LEN_HI_IDX  = 3;
   localparam int ROUND_BYTES = 64;
   localparam int NFRAMES     = 13;
   // pixels per frame, in the order the tests use them
   localparam int PIX_COUNT [NFRAMES] = '{64, 37, 16, 17, 18, 19, 20, 100, 77, 48, 60, 20, 22};

   logic                          rclk;
   logic                          resetb;
   logic                          enable;
   stream_dram_pkg::stream_word_t stream_in;
   logic                          read_mode;
   logic                          read_pop;
   logic                          read_rdy;
   logic [15:0]                   read_data;
   logic [7:0]                    drop_count;
   logic                          write_busy;
   logic                          read_busy;
   int                            cycle_count = 0;
   int                            cycle_limit = 2000;

   stream_dram_top DUT (.rclk, .resetb, .enable, .stream_in, .read_mode, .read_pop,
                        .read_rdy, .read_data, .drop_count, .write_busy, .read_busy);

   initial begin
      rclk = 1'b0;
      forever #5 rclk = ~rclk;
   end

   always @(posedge rclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit)
         abort_run($sformatf("timeout: run still busy after %0d cycles", cycle_count));
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   //////////////////////////////////////////////////
   // compare tasks
   task automatic check_half(input logic [15:0] got, input logic [15:0] exp, input int idx);
      if (got !== exp)
         abort_run($sformatf("error read_data half %0d got %h expected %h", idx, got, exp));
   endtask

   task automatic check_drops(input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) abort_run($sformatf("error drop_count got %h expected %h", got, exp));
   endtask

   task automatic check_base(input stream_dram_pkg::word_addr_t got,
                             input stream_dram_pkg::word_addr_t exp);
      if (got !== exp) abort_run($sformatf("error head.base got %h expected %h", got, exp));
   endtask

   //////////////////////////////////////////////////
   // frame model
   function automatic int rounded_bytes(input int npix);
      return ((HDR_HALVES * 2 + npix * 2 + ROUND_BYTES - 1) / ROUND_BYTES) * ROUND_BYTES;
   endfunction

   task automatic make_frame(input int npix, output half_q_t pix, output half_q_t hdr);
      pix = {};
      hdr = {};
      repeat (npix) pix.push_back(16'($urandom));
      repeat (HDR_HALVES) hdr.push_back(16'($urandom));
   endtask

   task automatic expect_frame(input half_q_t pix, input half_q_t hdr,
                               output half_q_t exp, output int total);
      int bytes;
      bytes = rounded_bytes(pix.size());
      exp   = {};
      foreach (hdr[i]) begin
         if (i == LEN_LO_IDX) exp.push_back(bytes[15:0]);
         else if (i == LEN_HI_IDX) exp.push_back(bytes[31:16]);
         else exp.push_back(hdr[i]);
      end
      foreach (pix[i]) exp.push_back(pix[i]);
      if (pix.size() % 2 == 1) exp.push_back(16'h0000);   // odd tail, zero upper half
      total = bytes / 2;
   endtask

   //////////////////////////////////////////////////
   // stream and read drivers
   task automatic drive_word(input stream_dram_pkg::dtype_e dt, input logic [15:0] value);
      @(posedge rclk);
      stream_in <= '{valid: 1'b1, dtype: dt, data: value};
   endtask

   task automatic wait_write_idle();
      @(posedge rclk);
      stream_in <= '0;
      do begin
         @(negedge rclk);
      end while (write_busy);
   endtask

   task automatic send_frame(input half_q_t pix, input half_q_t hdr);
      drive_word(stream_dram_pkg::DT_FRAME_START, 16'h0);
      foreach (pix[i]) drive_word(stream_dram_pkg::DT_PIXEL, pix[i]);
      drive_word(stream_dram_pkg::DT_FRAME_END, 16'h0);
      wait_write_idle();   // partial burst has to go out first
      drive_word(stream_dram_pkg::DT_HEADER_START, 16'h0);
      foreach (hdr[i]) drive_word(stream_dram_pkg::DT_HEADER, hdr[i]);
      drive_word(stream_dram_pkg::DT_HEADER_END, 16'h0);
      wait_write_idle();
   endtask

   task automatic set_read_mode(input logic mode);
      @(posedge rclk);
      read_mode <= mode;
   endtask

   task automatic read_frame(input half_q_t exp, input int total, input int stall_pct);
      int          got;
      logic        waiting;
      logic [15:0] held;
      got     = 0;
      waiting = 1'b0;
      held    = '0;
      while (got < total) begin
         @(posedge rclk);
         read_pop <= ($urandom % 100) >= stall_pct;
         @(negedge rclk);
         if (waiting) begin   // half-word offered last cycle but not taken
            if (!read_rdy) abort_run("read_rdy fell while a half-word was held back");
            check_half(read_data, held, got);
         end
         if (read_rdy && read_pop) begin
            if (got < exp.size()) check_half(read_data, exp[got], got);   // padding skipped
            got++;
         end
         waiting = read_rdy && !read_pop;
         held    = read_data;
      end
      @(posedge rclk);
      read_pop <= 1'b0;
      @(negedge rclk);
      if (read_rdy) abort_run("read_rdy still high after the last half-word of the frame");
      if (read_busy) abort_run("read_busy still high after the last half-word of the frame");
   endtask

   //////////////////////////////////////////////////
   // directed tests
   task automatic write_then_read(input int npix);
      half_q_t pix, hdr, exp;
      int      total;
      make_frame(npix, pix, hdr);
      expect_frame(pix, hdr, exp, total);
      send_frame(pix, hdr);
      set_read_mode(1'b1);
      read_frame(exp, total, 0);
      set_read_mode(1'b0);
   endtask

   task automatic queue_full_drop();
      half_q_t pix, hdr;
      half_q_t exp [5];
      int      total [5];
      int      f;
      for (f = 0; f < 5; f++) begin
         make_frame(PIX_COUNT[2 + f], pix, hdr);
         expect_frame(pix, hdr, exp[f], total[f]);
         send_frame(pix, hdr);
      end
      check_drops(drop_count, 8'd1);
      set_read_mode(1'b1);
      for (f = 0; f < 4; f++) read_frame(exp[f], total[f], 0);
      set_read_mode(1'b0);
   endtask

   task automatic back_pressure();
      half_q_t pix, hdr;
      half_q_t exp [2];
      int      total [2];
      int      f;
      for (f = 0; f < 2; f++) begin
         make_frame(PIX_COUNT[7 + f], pix, hdr);
         expect_frame(pix, hdr, exp[f], total[f]);
         send_frame(pix, hdr);
      end
      set_read_mode(1'b1);
      read_frame(exp[0], total[0], 50);
      read_frame(exp[1], total[1], 30);
      set_read_mode(1'b0);
   endtask

   task automatic simultaneous_traffic();
      half_q_t pa, ha, ea, pb, hb, eb;
      int      ta, tb;
      make_frame(PIX_COUNT[9], pa, ha);
      expect_frame(pa, ha, ea, ta);
      send_frame(pa, ha);
      make_frame(PIX_COUNT[10], pb, hb);
      expect_frame(pb, hb, eb, tb);
      set_read_mode(1'b1);
      fork
         send_frame(pb, hb);
         read_frame(ea, ta, 0);
      join
      read_frame(eb, tb, 0);
      set_read_mode(1'b0);
   endtask

   task automatic flush_restart();
      half_q_t pix, hdr, exp;
      int      total;
      make_frame(PIX_COUNT[11], pix, hdr);
      send_frame(pix, hdr);   // stays queued, read_mode is low
      @(posedge rclk);
      enable <= 1'b0;
      repeat (3) @(posedge rclk);
      enable <= 1'b1;
      set_read_mode(1'b1);
      repeat (40) begin
         @(negedge rclk);
         if (read_rdy) abort_run("read_rdy went high after a flush with no new frame");
      end
      set_read_mode(1'b0);
      make_frame(PIX_COUNT[12], pix, hdr);
      expect_frame(pix, hdr, exp, total);
      send_frame(pix, hdr);
      check_base(DUT.u_queue.head.base, '0);
      check_drops(drop_count, 8'd1);
      set_read_mode(1'b1);
      read_frame(exp, total, 0);
      set_read_mode(1'b0);
   endtask

   initial begin
      int k;
      void'($urandom(32'hca75bd1f));
      resetb    = 1'b0;
      enable    = 1'b1;
      stream_in = '0;
      read_mode = 1'b0;
      read_pop  = 1'b0;
      for (k = 0; k < NFRAMES; k++)
         cycle_limit += 4 * (PIX_COUNT[k] + HDR_HALVES + 4 + rounded_bytes(PIX_COUNT[k]) / 2);
      repeat (5) @(posedge rclk);
      resetb <= 1'b1;

      write_then_read(PIX_COUNT[0]);   // round trip
      write_then_read(PIX_COUNT[1]);   // odd pixel count, length patch and rounding
      queue_full_drop();
      back_pressure();
      simultaneous_traffic();
      flush_restart();

      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== verif/stream_dram_checker.sv ====
//////////////////////////////////////////////////
// arbiter, frame queue and writer buffer assertions,
// bound into stream_dram_top; credits modelled here
//////////////////////////////////////////////////
`timescale 1ns/1ps
module stream_dram_checker (
   input logic                   rclk,
   input logic                   resetb,
   input logic                   wr_req,
   input logic                   rd_req,
   input logic                   wr_grant,
   input logic                   rd_grant,
   input logic                   credit_return,
   input logic                   desc_push,
   input logic                   queue_full,
   input stream_dram_pkg::wcnt_t wbuf_count
);

   int credit_cnt;   // credits the arbiter should hold

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) credit_cnt <= stream_dram_pkg::CMD_CREDITS;
      else credit_cnt <= credit_cnt - int'(wr_grant || rd_grant) + int'(credit_return);
   end

   credit_range: assert property (@(posedge rclk) disable iff (!resetb)
      credit_cnt >= 0 && credit_cnt <= stream_dram_pkg::CMD_CREDITS)
      else $error("credit count out of range");

   grant_needs_credit: assert property (@(posedge rclk) disable iff (!resetb)
      (wr_grant || rd_grant) |-> credit_cnt > 0)
      else $error("grant issued with no credit left");

   wr_grant_req: assert property (@(posedge rclk) disable iff (!resetb) wr_grant |-> wr_req)
      else $error("writer granted without a request");

   rd_grant_req: assert property (@(posedge rclk) disable iff (!resetb) rd_grant |-> rd_req)
      else $error("reader granted without a request");

   one_grant: assert property (@(posedge rclk) disable iff (!resetb) !(wr_grant && rd_grant))
      else $error("writer and reader granted together");

   push_not_full: assert property (@(posedge rclk) disable iff (!resetb)
      desc_push |-> !queue_full)
      else $error("descriptor pushed into a full queue");

   wbuf_no_overflow: assert property (@(posedge rclk) disable iff (!resetb)
      wbuf_count <= stream_dram_pkg::wcnt_t'(stream_dram_pkg::WBUF_WORDS))
      else $error("writer buffer overflow");

endmodule

bind stream_dram_top stream_dram_checker u_checker (
   .rclk          (rclk),
   .resetb        (resetb),
   .wr_req        (wr_cmd.valid),
   .rd_req        (rd_cmd.valid),
   .wr_grant      (wr_grant),
   .rd_grant      (rd_grant),
   .credit_return (credit_return),
   .desc_push     (desc_push),
   .queue_full    (q_full),
   .wbuf_count    (u_writer.wcount)
);

// ==== hw/stream_dram_top.sv ====
//////////////////////////////////////////////////
// stream in, frame memory, register style read out
// single clock; enable low flushes every block
//////////////////////////////////////////////////
`timescale 1ns/1ps
module stream_dram_top (
   input  logic                          rclk,
   input  logic                          resetb,
   input  logic                          enable,
   input  stream_dram_pkg::stream_word_t stream_in,
   input  logic                          read_mode,
   input  logic                          read_pop,
   output logic                          read_rdy,
   output logic [15:0]                   read_data,
   output logic [7:0]                    drop_count,
   output logic                          write_busy,
   output logic                          read_busy
);

   stream_dram_pkg::mem_cmd_t    wr_cmd, rd_cmd, mem_cmd;
   stream_dram_pkg::frame_desc_t desc, head;
   stream_dram_pkg::rd_beat_t    rd_beat;
   logic [31:0]                  wr_data;
   logic                         wr_grant, rd_grant, wr_pop, credit_return;
   logic                         desc_push, desc_pop, q_empty, q_full;

   frame_writer u_writer (
      .rclk, .resetb, .enable, .stream_in,
      .grant(wr_grant), .wr_pop, .queue_full(q_full),
      .cmd_req(wr_cmd), .wr_data, .desc_push, .desc, .drop_count, .write_busy
   );

   frame_queue u_queue (
      .rclk, .resetb, .enable,
      .push(desc_push), .push_desc(desc), .pop(desc_pop),
      .head, .empty(q_empty), .full(q_full)
   );

   frame_reader u_reader (
      .rclk, .resetb, .enable, .read_mode, .head, .queue_empty(q_empty),
      .grant(rd_grant), .rd_beat, .read_pop,
      .desc_pop, .cmd_req(rd_cmd), .read_rdy, .read_data, .read_busy
   );

   burst_arbiter u_arb (
      .rclk, .resetb, .wr_cmd, .rd_cmd, .credit_return,
      .wr_grant, .rd_grant, .mem_cmd
   );

   frame_store_ram u_ram (
      .rclk, .resetb, .mem_cmd, .wr_data,
      .wr_pop, .rd_beat, .credit_return
   );

endmodule

// ==== hw/frame_store_ram.sv ====
//////////////////////////////////////////////////
// word memory executing queued bursts one word per
// cycle; the queue never overflows while the sender
// honours CMD_CREDITS
//////////////////////////////////////////////////
`timescale 1ns/1ps
module frame_store_ram (
   input  logic                      rclk,
   input  logic                      resetb,
   input  stream_dram_pkg::mem_cmd_t mem_cmd,
   input  logic [31:0]               wr_data,
   output logic                      wr_pop,
   output stream_dram_pkg::rd_beat_t rd_beat,
   output logic                      credit_return
);

   logic [31:0]                 mem [2**stream_dram_pkg::WORD_ADDR_W];
   stream_dram_pkg::mem_cmd_t   cmd_q [2];
   logic                        q_wr, q_rd;
   logic [1:0]                  q_cnt;
   logic                        busy, start, rd_valid;
   stream_dram_pkg::mem_op_e    cur_op;
   stream_dram_pkg::word_addr_t cur_addr;
   logic [3:0]                  left;      // words after the current one
   logic [31:0]                 rd_data;

   assign start   = !busy && q_cnt != '0;
   assign wr_pop  = busy && cur_op == stream_dram_pkg::MEM_WRITE;
   assign rd_beat = '{valid: rd_valid, data: rd_data};

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         q_wr          <= 1'b0;
         q_rd          <= 1'b0;
         q_cnt         <= '0;
         busy          <= 1'b0;
         cur_op        <= stream_dram_pkg::MEM_WRITE;
         cur_addr      <= '0;
         left          <= '0;
         rd_valid      <= 1'b0;
         credit_return <= 1'b0;
      end else begin
         if (mem_cmd.valid) q_wr <= !q_wr;
         q_cnt <= q_cnt + mem_cmd.valid - start;
         if (start) begin
            q_rd     <= !q_rd;
            busy     <= 1'b1;
            cur_op   <= cmd_q[q_rd].op;
            cur_addr <= cmd_q[q_rd].word_addr;
            left     <= cmd_q[q_rd].burst_len;
         end else if (busy) begin
            cur_addr <= cur_addr + 1'b1;
            left     <= left - 1'b1;
            if (left == '0) busy <= 1'b0;
         end
         rd_valid      <= busy && cur_op == stream_dram_pkg::MEM_READ;
         credit_return <= busy && left == '0;   // cycle after the last word
      end
   end

   always_ff @(posedge rclk) begin
      if (mem_cmd.valid) cmd_q[q_wr] <= mem_cmd;
      if (wr_pop) mem[cur_addr] <= wr_data;
      rd_data <= mem[cur_addr];
   end

endmodule

// ==== hw/burst_arbiter.sv ====
//////////////////////////////////////////////////
// one command per cycle to the ram while a credit
// is held; the last loser wins a tie
//////////////////////////////////////////////////
`timescale 1ns/1ps
module burst_arbiter (
   input  logic                      rclk,
   input  logic                      resetb,
   input  stream_dram_pkg::mem_cmd_t wr_cmd,
   input  stream_dram_pkg::mem_cmd_t rd_cmd,
   input  logic                      credit_return,
   output logic                      wr_grant,
   output logic                      rd_grant,
   output stream_dram_pkg::mem_cmd_t mem_cmd
);

   stream_dram_pkg::credit_t credits;
   logic                     last_rd;   // reader won the last grant
   logic                     have_credit, pick_rd;

   assign have_credit = credits != '0;
   assign pick_rd     = rd_cmd.valid && (!wr_cmd.valid || !last_rd);
   assign rd_grant    = have_credit && pick_rd;
   assign wr_grant    = have_credit && wr_cmd.valid && !pick_rd;

   always_comb begin
      mem_cmd = '0;
      if (rd_grant) mem_cmd = rd_cmd;
      else if (wr_grant) mem_cmd = wr_cmd;
   end

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         credits <= stream_dram_pkg::credit_t'(stream_dram_pkg::CMD_CREDITS);
         last_rd <= 1'b0;
      end else begin
         credits <= credits - (rd_grant || wr_grant) + credit_return;
         if (rd_grant) last_rd <= 1'b1;
         else if (wr_grant) last_rd <= 1'b0;
      end
   end

endmodule

// ==== hw/frame_reader.sv ====
//////////////////////////////////////////////////
// reads queued frames back by 16 word bursts and
// hands out half-words, low half first
// beats still owed after a flush are discarded
//////////////////////////////////////////////////
`timescale 1ns/1ps
module frame_reader (
   input  logic                         rclk,
   input  logic                         resetb,
   input  logic                         enable,
   input  logic                         read_mode,
   input  stream_dram_pkg::frame_desc_t head,
   input  logic                         queue_empty,
   input  logic                         grant,
   input  stream_dram_pkg::rd_beat_t    rd_beat,
   input  logic                         read_pop,
   output logic                         desc_pop,
   output stream_dram_pkg::mem_cmd_t    cmd_req,
   output logic                         read_rdy,
   output logic [15:0]                  read_data,
   output logic                         read_busy
);

   stream_dram_pkg::rd_state_e          state;
   logic [31:0]                         rbuf [stream_dram_pkg::RBUF_WORDS];
   stream_dram_pkg::rptr_t              wptr, rptr;
   stream_dram_pkg::rcnt_t              rcount, outstanding, junk;
   stream_dram_pkg::word_addr_t         rd_addr, req_left;
   logic [stream_dram_pkg::WORD_ADDR_W:0] out_left;   // half-words left in the frame
   logic                                half_sel, take, beat_keep;

   assign desc_pop  = enable && state == stream_dram_pkg::RD_IDLE && read_mode && !queue_empty;
   assign read_rdy  = rcount != '0;
   assign take      = read_pop && read_rdy;
   assign read_data = half_sel ? rbuf[rptr][31:16] : rbuf[rptr][15:0];
   assign beat_keep = rd_beat.valid && junk == '0;
   assign read_busy = state == stream_dram_pkg::RD_FETCH;

   // only ask when the whole burst fits
   assign cmd_req.valid     = enable && state == stream_dram_pkg::RD_FETCH && req_left != '0 &&
                              rcount + outstanding <= stream_dram_pkg::rcnt_t'(
                              stream_dram_pkg::RBUF_WORDS - stream_dram_pkg::BURST_WORDS);
   assign cmd_req.op        = stream_dram_pkg::MEM_READ;
   assign cmd_req.word_addr = rd_addr;
   assign cmd_req.burst_len = 4'(stream_dram_pkg::BURST_WORDS - 1);

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         state       <= stream_dram_pkg::RD_IDLE;
         wptr        <= '0;
         rptr        <= '0;
         rcount      <= '0;
         outstanding <= '0;
         junk        <= '0;
         rd_addr     <= '0;
         req_left    <= '0;
         out_left    <= '0;
         half_sel    <= 1'b0;
      end else if (!enable) begin
         state       <= stream_dram_pkg::RD_IDLE;
         wptr        <= '0;
         rptr        <= '0;
         rcount      <= '0;
         req_left    <= '0;
         out_left    <= '0;
         half_sel    <= 1'b0;
         outstanding <= '0;
         junk        <= junk + outstanding - rd_beat.valid;
      end else begin
         if (desc_pop) begin
            state    <= stream_dram_pkg::RD_FETCH;
            rd_addr  <= head.base;
            req_left <= head.len_words;
            out_left <= {head.len_words, 1'b0};
         end
         if (grant) begin
            rd_addr  <= rd_addr + stream_dram_pkg::word_addr_t'(stream_dram_pkg::BURST_WORDS);
            req_left <= req_left - stream_dram_pkg::word_addr_t'(stream_dram_pkg::BURST_WORDS);
         end
         outstanding <= outstanding - beat_keep +
                        (grant ? stream_dram_pkg::rcnt_t'(stream_dram_pkg::BURST_WORDS) : '0);
         if (rd_beat.valid && junk != '0) junk <= junk - 1'b1;
         wptr   <= wptr + beat_keep;
         rcount <= rcount + beat_keep - (take && half_sel);
         if (take) begin
            half_sel <= !half_sel;
            rptr     <= rptr + half_sel;
            out_left <= out_left - 1'b1;
            if (out_left == 1) state <= stream_dram_pkg::RD_IDLE;   // frame delivered
         end
      end
   end

   always_ff @(posedge rclk) begin
      if (enable && beat_keep) rbuf[wptr] <= rd_beat.data;
   end

endmodule

// ==== hw/frame_queue.sv ====
//////////////////////////////////////////////////
// committed frame descriptors, oldest at head
// push on full and pop on empty are ignored
//////////////////////////////////////////////////
`timescale 1ns/1ps
module frame_queue (
   input  logic                         rclk,
   input  logic                         resetb,
   input  logic                         enable,
   input  logic                         push,
   input  stream_dram_pkg::frame_desc_t push_desc,
   input  logic                         pop,
   output stream_dram_pkg::frame_desc_t head,
   output logic                         empty,
   output logic                         full
);

   stream_dram_pkg::frame_desc_t slots [stream_dram_pkg::FRAME_QUEUE_DEPTH];
   stream_dram_pkg::qptr_t       wptr, rptr;
   stream_dram_pkg::qcnt_t       count;
   logic                         do_push, do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;
   assign head    = slots[rptr];
   assign empty   = count == '0;
   assign full    = count == stream_dram_pkg::qcnt_t'(stream_dram_pkg::FRAME_QUEUE_DEPTH);

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else if (!enable) begin
         wptr  <= '0;   // flush
         rptr  <= '0;
         count <= '0;
      end else begin
         wptr  <= wptr + do_push;
         rptr  <= rptr + do_pop;
         count <= count + do_push - do_pop;
      end
   end

   always_ff @(posedge rclk) begin
      if (do_push) slots[wptr] <= push_desc;
   end

endmodule

// ==== hw/frame_writer.sv ====
//////////////////////////////////////////////////
// packs the stream into words and writes each frame
// the stream must idle after FRAME_END and HEADER_END
// until the partial burst is granted; at most 16 header
// half-words per frame
//////////////////////////////////////////////////
`timescale 1ns/1ps
module frame_writer (
   input  logic                          rclk,
   input  logic                          resetb,
   input  logic                          enable,
   input  stream_dram_pkg::stream_word_t stream_in,
   input  logic                          grant,
   input  logic                          wr_pop,
   input  logic                          queue_full,
   output stream_dram_pkg::mem_cmd_t     cmd_req,
   output logic [31:0]                   wr_data,
   output logic                          desc_push,
   output stream_dram_pkg::frame_desc_t  desc,
   output logic [7:0]                    drop_count,
   output logic                          write_busy
);

   stream_dram_pkg::wr_state_e  state;
   logic [31:0]                 wbuf [stream_dram_pkg::WBUF_WORDS];
   stream_dram_pkg::wptr_t      wr_ptr, rd_ptr;
   stream_dram_pkg::wcnt_t      wcount;     // words held until the ram pops them
   stream_dram_pkg::wcnt_t      pend;       // words not yet covered by a command
   stream_dram_pkg::wcnt_t      seg_left;
   stream_dram_pkg::wcnt_t      burst_words, pend_nxt;
   stream_dram_pkg::word_addr_t base, wr_addr;
   stream_dram_pkg::half_cnt_t  pix_cnt;
   stream_dram_pkg::byte_len_t  frame_bytes, round_bytes;
   logic [15:0]                 lo_half, data_mux;
   logic [31:0]                 push_word;
   logic [4:0]                  hdr_idx;
   logic                        half_sel, is_data, is_end, word_push, flushing, commit;

   assign is_data = stream_in.valid && (stream_in.dtype == stream_dram_pkg::DT_PIXEL ||
                                        stream_in.dtype == stream_dram_pkg::DT_HEADER);
   assign is_end  = stream_in.valid && (stream_in.dtype == stream_dram_pkg::DT_FRAME_END ||
                                        stream_in.dtype == stream_dram_pkg::DT_HEADER_END);

   // header area plus pixels, rounded up to 64 bytes
   assign frame_bytes = {pix_cnt, 1'b0} + stream_dram_pkg::HDR_BYTES;
   assign round_bytes = (frame_bytes + stream_dram_pkg::byte_len_t'(63)) &
                        ~stream_dram_pkg::byte_len_t'(63);

   always_comb begin
      data_mux = stream_in.data;
      if (stream_in.dtype == stream_dram_pkg::DT_HEADER) begin
         if (int'(hdr_idx) == stream_dram_pkg::HDR_LEN_LO) data_mux = round_bytes[15:0];
         if (int'(hdr_idx) == stream_dram_pkg::HDR_LEN_HI) data_mux = 16'(round_bytes >> 16);
      end
   end

   assign word_push = enable && half_sel && (is_data || is_end);
   assign push_word = is_data ? {data_mux, lo_half} : {16'h0, lo_half};   // odd tail padded

   //////////////////////////////////////////////////
   // command side
   assign flushing    = state == stream_dram_pkg::WR_FLUSH_FRAME ||
                        state == stream_dram_pkg::WR_FLUSH_HEADER;
   assign burst_words = (flushing && seg_left < stream_dram_pkg::wcnt_t'(16)) ?
                        seg_left : stream_dram_pkg::wcnt_t'(stream_dram_pkg::BURST_WORDS);
   assign pend_nxt    = pend + word_push - (grant ? burst_words : '0);
   assign commit      = enable && state == stream_dram_pkg::WR_FLUSH_HEADER && seg_left == '0;

   assign cmd_req.valid     = enable && (flushing ? seg_left != '0 :
                              pend >= stream_dram_pkg::wcnt_t'(stream_dram_pkg::BURST_WORDS));
   assign cmd_req.op        = stream_dram_pkg::MEM_WRITE;
   assign cmd_req.word_addr = wr_addr;
   assign cmd_req.burst_len = 4'(burst_words - 1'b1);

   assign wr_data    = wbuf[rd_ptr];
   assign write_busy = flushing || wcount != '0;

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         state      <= stream_dram_pkg::WR_FRAME;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         wcount     <= '0;
         pend       <= '0;
         seg_left   <= '0;
         base       <= '0;
         wr_addr    <= '0;
         pix_cnt    <= '0;
         hdr_idx    <= '0;
         half_sel   <= 1'b0;
         desc_push  <= 1'b0;
         drop_count <= '0;
      end else if (!enable) begin
         // unissued words are dropped, issued ones still drain to the ram
         wr_ptr    <= wr_ptr - stream_dram_pkg::wptr_t'(pend);
         wcount    <= wcount - pend - wr_pop;
         rd_ptr    <= rd_ptr + wr_pop;
         pend      <= '0;
         seg_left  <= '0;
         base      <= '0;
         wr_addr   <= '0;
         half_sel  <= 1'b0;
         desc_push <= 1'b0;
         state     <= stream_dram_pkg::WR_FRAME;
      end else begin
         desc_push <= commit && !queue_full;
         rd_ptr    <= rd_ptr + wr_pop;
         wr_ptr    <= wr_ptr + word_push;
         wcount    <= wcount + word_push - wr_pop;
         pend      <= pend_nxt;
         if (grant) wr_addr <= wr_addr + stream_dram_pkg::word_addr_t'(burst_words);
         if (grant && flushing) seg_left <= seg_left - burst_words;
         if (is_data) half_sel <= !half_sel;
         if (stream_in.valid && stream_in.dtype == stream_dram_pkg::DT_PIXEL) pix_cnt <= pix_cnt + 1'b1;
         if (stream_in.valid && stream_in.dtype == stream_dram_pkg::DT_HEADER) hdr_idx <= hdr_idx + 1'b1;

         if (state == stream_dram_pkg::WR_FLUSH_FRAME && seg_left == '0) begin
            state   <= stream_dram_pkg::WR_HEADER;
            wr_addr <= base;                  // header goes back to the frame base
         end
         if (commit) begin
            state <= stream_dram_pkg::WR_FRAME;
            if (queue_full) drop_count <= drop_count + 1'b1;
            else base <= base + round_bytes[stream_dram_pkg::WORD_ADDR_W+1:2];
         end

         if (stream_in.valid) begin
            case (stream_in.dtype)
               stream_dram_pkg::DT_FRAME_START: begin
                  state    <= stream_dram_pkg::WR_FRAME;
                  pix_cnt  <= '0;
                  half_sel <= 1'b0;
                  wr_addr  <= base + stream_dram_pkg::word_addr_t'(stream_dram_pkg::HEADER_WORDS);
               end
               stream_dram_pkg::DT_HEADER_START: hdr_idx <= '0;
               stream_dram_pkg::DT_FRAME_END: begin
                  state    <= stream_dram_pkg::WR_FLUSH_FRAME;
                  seg_left <= pend_nxt;
                  half_sel <= 1'b0;
               end
               stream_dram_pkg::DT_HEADER_END: begin
                  state    <= stream_dram_pkg::WR_FLUSH_HEADER;
                  seg_left <= pend_nxt;
                  half_sel <= 1'b0;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge rclk) begin
      if (enable && is_data && !half_sel) lo_half <= data_mux;
      if (word_push) wbuf[wr_ptr] <= push_word;
      if (commit) desc <= '{base: base, len_words: round_bytes[stream_dram_pkg::WORD_ADDR_W+1:2]};
   end

endmodule

// ==== hw/stream_dram_pkg.sv ====
//////////////////////////////////////////////////
// types and sizes shared by the frame store path
// buffer and queue depths must be powers of two
//////////////////////////////////////////////////
package stream_dram_pkg;

   localparam int WORD_ADDR_W       = 14;   // 16 K words of frame memory
   localparam int BURST_WORDS       = 16;
   localparam int HEADER_WORDS      = 8;
   localparam int HDR_LEN_LO        = 2;
   localparam int HDR_LEN_HI        = 3;
   localparam int FRAME_QUEUE_DEPTH = 4;
   localparam int CMD_CREDITS       = 2;
   localparam int WBUF_WORDS        = 32;
   localparam int RBUF_WORDS        = 32;

   typedef logic [WORD_ADDR_W-1:0]               word_addr_t;
   typedef logic [WORD_ADDR_W+1:0]               half_cnt_t;
   typedef logic [WORD_ADDR_W+2:0]               byte_len_t;
   typedef logic [$clog2(WBUF_WORDS)-1:0]        wptr_t;
   typedef logic [$clog2(WBUF_WORDS):0]          wcnt_t;
   typedef logic [$clog2(RBUF_WORDS)-1:0]        rptr_t;
   typedef logic [$clog2(RBUF_WORDS):0]          rcnt_t;
   typedef logic [$clog2(FRAME_QUEUE_DEPTH)-1:0] qptr_t;
   typedef logic [$clog2(FRAME_QUEUE_DEPTH):0]   qcnt_t;
   typedef logic [$clog2(CMD_CREDITS+1)-1:0]     credit_t;

   localparam byte_len_t HDR_BYTES = byte_len_t'(HEADER_WORDS * 4);

   typedef enum logic [2:0] {
      DT_FRAME_START,
      DT_PIXEL,
      DT_FRAME_END,
      DT_HEADER_START,
      DT_HEADER,
      DT_HEADER_END,
      DT_OTHER
   } dtype_e;

   typedef enum logic {MEM_WRITE, MEM_READ} mem_op_e;

   typedef enum logic [1:0] {WR_FRAME, WR_HEADER, WR_FLUSH_FRAME, WR_FLUSH_HEADER} wr_state_e;
   typedef enum logic {RD_IDLE, RD_FETCH} rd_state_e;

   typedef struct packed {
      logic        valid;
      dtype_e      dtype;
      logic [15:0] data;
   } stream_word_t;

   typedef struct packed {
      logic       valid;
      mem_op_e    op;
      word_addr_t word_addr;
      logic [3:0] burst_len;   // words minus one
   } mem_cmd_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
   } rd_beat_t;

   typedef struct packed {
      word_addr_t base;
      word_addr_t len_words;   // multiple of BURST_WORDS
   } frame_desc_t;

endpackage
